/* Makefile */
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = tb_simmem_write_resp_delay
FILELIST = build.f
OUTDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OUTDIR)
	./$(OUTDIR)/V$(TOP)

clean:
	rm -rf $(OUTDIR)

/* build.f */
src/simmem_pkg.sv
src/simmem_delay_bank.sv
src/simmem_resp_store.sv
src/simmem_write_resp_delay.sv
sim/tb_simmem_write_resp_delay.sv

/* sim/tb_simmem_write_resp_delay.sv */
// Directed testbench of the write-response delay path
// Drives requests on the falling edge, predicts each response and its cycle
// in a scoreboard and checks every response that leaves the DUT

`default_nettype none

module tb_simmem_write_resp_delay;

  import simmem_pkg::*;

  localparam int unsigned ClkPeriod    = 8;
  localparam int unsigned RandReqs     = 200;
  localparam int unsigned RandMaxDelay = 60;
  localparam int unsigned RandMaxGap   = 3;
  // Delays of the directed tests plus one cycle per request, the random run
  // at its worst case and a margin for the drain phases
  localparam int unsigned WatchdogCycles = 20 + (53 + 6) + (50 + 3) + (9 + 2)
      + (800 + 20 + 10) + RandReqs * (RandMaxDelay + RandMaxGap + 1) + 2000;

  // Pending response with expect_at set to -1 when any cycle after due is fine
  typedef struct {
    wr_resp_t resp;
    int       delay;
    int       req_cyc;
    int       due;
    int       expect_at;
  } sb_entry_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  delay_req_t req_i;
  logic       resp_valid_o;
  wr_resp_t   resp_o;
  logic       full_o;

  // Number of rising edges seen so far
  int         cyc = 0;
  string      test_name;
  sb_entry_t  sb[$];

  simmem_write_resp_delay simmem_write_resp_delay_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .full_o       (full_o)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Run stopped at cycle %0d", cyc);
  endtask

  task automatic check_resp(input wr_resp_t exp, input wr_resp_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected id %0h code %0h, actual id %0h code %0h",
               test_name, exp.id, exp.code, act.id, act.code);
      abort_run("Response payload does not match");
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: %s expected %0b, actual %0b", test_name, what, exp, act);
      abort_run($sformatf("Flag %s has the wrong level", what));
    end
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////

  // Outputs are sampled on the falling edge halfway between updates
  always @(negedge clk_i) begin : monitor
    int idx;
    idx = -1;
    if (rst_ni && resp_valid_o) begin
      // A response pinned to this exact cycle takes precedence
      foreach (sb[i]) begin
        if (idx < 0 && sb[i].expect_at == cyc) begin
          idx = i;
        end
      end
      if (idx >= 0) begin
        check_resp(sb[idx].resp, resp_o);
      end else begin
        // Otherwise the oldest matching entry that is already due
        foreach (sb[i]) begin
          if (idx < 0 && sb[i].expect_at < 0 && sb[i].due <= cyc && sb[i].resp == resp_o) begin
            idx = i;
          end
        end
      end
      if (idx < 0) begin
        abort_run($sformatf("Unexpected response id %0h code %0h in test %s at cycle %0d",
                            resp_o.id, resp_o.code, test_name, cyc));
      end else begin
        sb.delete(idx);
      end
    end
    foreach (sb[i]) begin
      if (sb[i].expect_at >= 0 && sb[i].expect_at <= cyc) begin
        abort_run($sformatf("Missing response id %0h (delay %0d) due at cycle %0d in test %s",
                            sb[i].resp.id, sb[i].delay, sb[i].expect_at, test_name));
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Called on a falling edge and returns on the next one
  task automatic send_req(input logic [IdWidth-1:0] id, input logic [1:0] code,
                          input int delay, input int extra);
    sb_entry_t e;
    req_valid_i     = 1'b1;
    req_i.resp.id   = id;
    req_i.resp.code = code;
    req_i.delay     = DelayWidth'(delay);
    // The DUT drops a request that finds every slot taken
    if (!full_o) begin
      e.resp      = '{id: id, code: code};
      e.delay     = delay;
      e.req_cyc   = cyc + 1;
      e.due       = e.req_cyc + ((delay > 2) ? delay : 2);
      e.expect_at = (extra < 0) ? -1 : e.due + extra;
      sb.push_back(e);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (sb.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > limit) begin
        abort_run($sformatf("%s: %0d responses never arrived", test_name, sb.size()));
      end
    end
    // Idle cycles give a stray response the chance to show up
    repeat (4) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    repeat (20) begin
      @(negedge clk_i);
      check_bit("resp_valid_o", 1'b0, resp_valid_o);
      check_bit("full_o", 1'b0, full_o);
    end
  endtask

  task automatic test_isolated();
    int delays [6] = '{0, 1, 2, 3, 7, 40};
    test_name = "isolated";
    foreach (delays[k]) begin
      send_req(IdWidth'(k + 1), 2'(k), delays[k], 0);
      wait_drain(delays[k] + 10);
    end
  endtask

  task automatic test_reorder();
    test_name = "reorder";
    send_req(4'hA, 2'b00, 30, 0);
    send_req(4'hB, 2'b01, 5, 0);
    send_req(4'hC, 2'b10, 15, 0);
    wait_drain(50);
  endtask

  // Both entries expire on the same edge and slot 1 waits behind slot 0
  task automatic test_collision();
    test_name = "collision";
    send_req(4'h1, 2'b00, 5, 0);
    send_req(4'h2, 2'b11, 4, 1);
    wait_drain(20);
  endtask

  task automatic test_full_drop();
    int n;
    test_name = "full_drop";
    for (int k = 0; k < int'(NumSlots); k++) begin
      send_req(IdWidth'(k), 2'b00, 100, 0);
    end
    check_bit("full_o", 1'b1, full_o);
    send_req(4'hE, 2'b11, 5, 0);
    n = 0;
    while (!resp_valid_o) begin
      @(negedge clk_i);
      n++;
      if (n > 120) begin
        abort_run("full_drop: the first response never arrived");
      end
    end
    check_bit("full_o", 1'b0, full_o);
    // Long enough to land after the remaining seven responses
    send_req(4'hF, 2'b01, 20, 0);
    wait_drain(120);
  endtask

  task automatic test_random();
    int delay;
    int gap;
    test_name = "random";
    for (int k = 0; k < int'(RandReqs); k++) begin
      while (full_o) begin
        @(negedge clk_i);
      end
      delay = int'($urandom_range(RandMaxDelay, 0));
      send_req(IdWidth'($urandom), 2'($urandom), delay, -1);
      gap = int'($urandom_range(RandMaxGap, 0));
      repeat (gap) @(negedge clk_i);
    end
    wait_drain(int'(RandMaxDelay + 4 * NumSlots));
  endtask

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    abort_run($sformatf("Watchdog expired after %0d cycles in test %s",
                        WatchdogCycles, test_name));
  end

  initial begin
    void'($urandom(74175));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    test_name   = "init";
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_isolated();
    test_reorder();
    test_collision();
    test_full_drop();
    test_random();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* src/simmem_delay_bank.sv */
// Delay bank of the write-response path
// Keeps one countdown counter per slot and a registered mask of the slots
// whose responses are allowed to leave the store

`default_nettype none

module simmem_delay_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Allocation from the store, valid for one cycle per accepted request
  input  simmem_pkg::bank_entry_t  bank_entry_i,

  // Slot that the store is releasing this cycle
  input  simmem_pkg::slot_mask_t   released_onehot_i,
  output simmem_pkg::slot_mask_t   release_en_o
);

  import simmem_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Countdown counters, zero means idle
  logic [DelayWidth-1:0] counters_d [NumSlots];
  logic [DelayWidth-1:0] counters_q [NumSlots];

  // Slots that become releasable on the next edge
  slot_mask_t new_release;

  slot_mask_t release_en_d;
  slot_mask_t release_en_q;

  // Delays of two cycles or less are already covered by the pipeline
  logic short_delay;

  assign short_delay = bank_entry_i.delay <= DelayWidth'(2);

  //////////////////////////////////////////////////
  // Per-slot counters
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NumSlots; i++) begin : gen_slot
    always_comb begin : counter_comb
      new_release[i] = 1'b0;
      counters_d[i]  = counters_q[i];

      // A running counter steps down once per cycle
      if (counters_q[i] != '0) begin
        counters_d[i] = counters_q[i] - DelayWidth'(1);
      end

      // The step from one to zero marks expiry
      // A new entry never targets a slot whose counter is still running
      if (counters_q[i] == DelayWidth'(1)) begin
        new_release[i] = 1'b1;
      end else if (bank_entry_i.valid && bank_entry_i.slot == SlotIdxWidth'(i)) begin
        if (short_delay) begin
          new_release[i] = 1'b1;
        end else begin
          // Two cycles are spent in the entry register and the release register
          counters_d[i] = bank_entry_i.delay - DelayWidth'(2);
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        counters_q[i] <= '0;
      end else begin
        counters_q[i] <= counters_d[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Release enable mask
  //////////////////////////////////////////////////

  // The released slot is cleared, expired and short entries are added
  // Both never hit the same bit since a released slot has no running counter
  always_comb begin
    release_en_d = release_en_q & ~released_onehot_i;
    release_en_d = release_en_d | new_release;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      release_en_q <= '0;
    end else begin
      release_en_q <= release_en_d;
    end
  end

  assign release_en_o = release_en_q;

endmodule

`default_nettype wire

/* src/simmem_pkg.sv */
// Shared sizes and types of the simulated memory controller write-response path
// Holds the slot count, the counter width and the structs passed between the
// response store and the delay bank

`default_nettype none

package simmem_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Number of response slots held in the store and the bank
  localparam int unsigned NumSlots = 8;
  // Width of a slot index
  localparam int unsigned SlotIdxWidth = 3;
  // Width of the requested delay and of each countdown counter
  localparam int unsigned DelayWidth = 8;
  // Width of the transaction ID carried by a response
  localparam int unsigned IdWidth = 4;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Write response as it leaves the controller, code follows the AXI BRESP encoding
  typedef struct packed {
    logic [IdWidth-1:0] id;
    logic [1:0]         code;
  } wr_resp_t;

  // Incoming request, the response to return and its delay in clock cycles
  typedef struct packed {
    wr_resp_t              resp;
    logic [DelayWidth-1:0] delay;
  } delay_req_t;

  // Registered allocation announced by the store to the delay bank
  typedef struct packed {
    logic                    valid;
    logic [SlotIdxWidth-1:0] slot;
    logic [DelayWidth-1:0]   delay;
  } bank_entry_t;

  // One bit per slot
  typedef logic [NumSlots-1:0] slot_mask_t;

endpackage

`default_nettype wire

/* src/simmem_resp_store.sv */
// Response store of the write-response path
// Allocates the lowest free slot to each incoming request, keeps the payload,
// announces the allocation to the delay bank and sends out the lowest
// release-enabled response, one per cycle

`default_nettype none

module simmem_resp_store (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Incoming request strobe
  input  logic                     req_valid_i,
  input  simmem_pkg::delay_req_t   req_i,

  // Interface to the delay bank
  input  simmem_pkg::slot_mask_t   release_en_i,
  output simmem_pkg::bank_entry_t  bank_entry_o,
  output simmem_pkg::slot_mask_t   released_onehot_o,

  // Outgoing response strobe
  output logic                     full_o,
  output logic                     resp_valid_o,
  output simmem_pkg::wr_resp_t     resp_o
);

  import simmem_pkg::*;

  // Index of the lowest set bit, zero for an empty mask
  function automatic logic [SlotIdxWidth-1:0] lowest_idx(slot_mask_t mask);
    logic [SlotIdxWidth-1:0] idx;
    idx = '0;
    // Scan downwards so that the lowest set bit wins
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = SlotIdxWidth'(i);
      end
    end
    return idx;
  endfunction

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  slot_mask_t occupied_d;
  slot_mask_t occupied_q;

  // Stored responses, one per slot
  wr_resp_t payload_q [NumSlots];

  logic [SlotIdxWidth-1:0] free_idx;
  slot_mask_t              alloc_onehot;
  logic                    req_accept;

  logic [SlotIdxWidth-1:0] released_idx;
  logic                    release_any;
  slot_mask_t              released_onehot;

  // Registered allocation towards the bank
  logic                    bank_valid_q;
  logic [SlotIdxWidth-1:0] bank_slot_q;
  logic [DelayWidth-1:0]   bank_delay_q;

  // Registered output
  logic                    resp_valid_q;
  wr_resp_t                resp_q;

  //////////////////////////////////////////////////
  // Allocation
  //////////////////////////////////////////////////

  // Full when every slot holds a response
  assign full_o = &occupied_q;

  // Requests arriving while full are dropped
  assign req_accept   = req_valid_i & ~full_o;
  assign free_idx     = lowest_idx(~occupied_q);
  assign alloc_onehot = req_accept ? (slot_mask_t'(1) << free_idx) : '0;

  //////////////////////////////////////////////////
  // Release selection
  //////////////////////////////////////////////////

  // Fixed priority, the lowest enabled slot leaves first
  assign release_any     = |release_en_i;
  assign released_idx    = lowest_idx(release_en_i);
  assign released_onehot = release_any ? (slot_mask_t'(1) << released_idx) : '0;

  assign released_onehot_o = released_onehot;

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////

  // A slot is never allocated and released in the same cycle
  // since allocation only picks free slots
  assign occupied_d = (occupied_q & ~released_onehot) | alloc_onehot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

  // Payload written into the newly allocated slot
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      payload_q[free_idx] <= req_i.resp;
    end
  end

  //////////////////////////////////////////////////
  // Bank entry register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_valid_q <= 1'b0;
    end else begin
      bank_valid_q <= req_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      bank_slot_q  <= free_idx;
      bank_delay_q <= req_i.delay;
    end
  end

  assign bank_entry_o = '{valid: bank_valid_q, slot: bank_slot_q, delay: bank_delay_q};

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  // One response per cycle, valid for a single cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= release_any;
    end
  end

  always_ff @(posedge clk_i) begin
    if (release_any) begin
      resp_q <= payload_q[released_idx];
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

`default_nettype wire

/* src/simmem_write_resp_delay.sv */
// Write-response delay path of the simulated memory controller
// Holds each write response for its requested number of cycles and
// returns at most one response per cycle

`default_nettype none

module simmem_write_resp_delay (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Request side, single-cycle strobe
  input  logic                    req_valid_i,
  input  simmem_pkg::delay_req_t  req_i,

  // Response side, single-cycle strobe without back-pressure
  output logic                    resp_valid_o,
  output simmem_pkg::wr_resp_t    resp_o,

  // High while every slot is occupied
  output logic                    full_o
);

  import simmem_pkg::*;

  //////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////

  // Allocation handed from the store to the bank
  bank_entry_t bank_entry;
  // Slots whose delay has elapsed
  slot_mask_t  release_en;
  // Slot leaving the store this cycle
  slot_mask_t  released_onehot;

  // Payload storage, allocation and output selection
  simmem_resp_store simmem_resp_store_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_i             (req_i),
    .release_en_i      (release_en),
    .bank_entry_o      (bank_entry),
    .released_onehot_o (released_onehot),
    .full_o            (full_o),
    .resp_valid_o      (resp_valid_o),
    .resp_o            (resp_o)
  );

  // Per-slot countdown and release enables
  simmem_delay_bank simmem_delay_bank_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bank_entry_i      (bank_entry),
    .released_onehot_i (released_onehot),
    .release_en_o      (release_en)
  );

endmodule

`default_nettype wire
